// ==== all.f ====
hw/policer_pkg.sv
hw/policer_config_table.sv
hw/bucket_store.sv
hw/drop_marker.sv
hw/ingress_policer.sv
tb/policer_checker.sv
tb/policer_tb.sv

// ==== hw/bucket_store.sv ====
// Token bucket levels, one per ingress port, drained by CIR every cycle.
// Accepted packets charge their port's bucket; the new level shows one cycle later.
`default_nettype none

module bucket_store
    import policer_pkg::*;
(
    input  logic      core_clk_ifc,
    input  logic      timer_reset,

    input  cir_t      cir [num_ports],

    input  logic      charge_valid,
    input  port_t     charge_port,
    input  byte_len_t charge_len,

    output level_t    levels [num_ports]
);

    ////////////////////////////////////////////////////////////
    // Charge alignment

    // Byte length sits on the whole-byte bits of the level
    level_t charge_amt;

    assign charge_amt = level_t'({charge_len, {level_frac_bits{1'b0}}});

    ////////////////////////////////////////////////////////////
    // Next level per port

    level_t cir_ext   [num_ports];
    level_t drained   [num_ports];
    level_t level_nxt [num_ports];

    always_comb begin
        for (int i = 0; i < num_ports; i++) begin
            // 16.8 CIR widened to the 24.8 level format
            cir_ext[i] = level_t'(cir[i]);

            // Drain first, floor at empty
            if (levels[i] > cir_ext[i]) begin
                drained[i] = levels[i] - cir_ext[i];
            end else begin
                drained[i] = '0;
            end

            // Then add the charge, if it is for this port
            if (charge_valid && (charge_port == port_t'(i))) begin
                level_nxt[i] = drained[i] + charge_amt;
            end else begin
                level_nxt[i] = drained[i];
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Level registers

    // The marker never charges past CBS, so the sum stays inside 24 whole bits
    always_ff @(posedge core_clk_ifc) begin
        if (timer_reset) begin
            for (int i = 0; i < num_ports; i++) begin
                levels[i] <= '0;
            end
        end else begin
            for (int i = 0; i < num_ports; i++) begin
                levels[i] <= level_nxt[i];
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/drop_marker.sv ====
// Judges each descriptor against its port's bucket and CBS, issues the charge
// for accepted packets and registers the descriptor with its drop mark.
`default_nettype none

module drop_marker
    import policer_pkg::*;
(
    input  logic                 core_clk_ifc,
    input  logic                 timer_reset,

    input  logic [num_ports-1:0] enable,
    input  cbs_t                 cbs [num_ports],
    input  level_t               levels [num_ports],

    input  logic                 desc_valid,
    input  port_t                desc_ing_port,
    input  port_t                desc_egr_port,
    input  prio_t                desc_prio,
    input  byte_len_t            desc_len,

    output logic                 charge_valid,
    output port_t                charge_port,
    output byte_len_t            charge_len,

    output logic                 out_valid,
    output port_t                out_ing_port,
    output port_t                out_egr_port,
    output prio_t                out_prio,
    output byte_len_t            out_len,
    output logic                 out_drop_mark
);

    ////////////////////////////////////////////////////////////
    // Bucket select

    level_t    sel_level;
    cbs_t      sel_cbs;
    logic      sel_enable;
    byte_sum_t need_bytes;
    logic      over_cbs;
    logic      drop_mark;

    // Out of range ingress ports select nothing and behave as disabled
    always_comb begin
        sel_level  = '0;
        sel_cbs    = '0;
        sel_enable = 1'b0;
        for (int i = 0; i < num_ports; i++) begin
            if (desc_ing_port == port_t'(i)) begin
                sel_level  = levels[i];
                sel_cbs    = cbs[i];
                sel_enable = enable[i];
            end
        end
    end

    // Any leftover fraction rounds the bucket up by one byte
    assign need_bytes = byte_sum_t'(desc_len)
                      + byte_sum_t'(sel_level[level_bits-1:level_frac_bits])
                      + byte_sum_t'(|sel_level[level_frac_bits-1:0]);

    assign over_cbs  = need_bytes > byte_sum_t'(sel_cbs);
    assign drop_mark = sel_enable && over_cbs;

    ////////////////////////////////////////////////////////////
    // Charge to bucket_store

    assign charge_valid = desc_valid && sel_enable && !over_cbs;
    assign charge_port  = desc_ing_port;
    assign charge_len   = desc_len;

    ////////////////////////////////////////////////////////////
    // Output register

    always_ff @(posedge core_clk_ifc) begin
        if (timer_reset) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= desc_valid;
        end
    end

    // Descriptor fields only qualified by out_valid
    always_ff @(posedge core_clk_ifc) begin
        out_ing_port  <= desc_ing_port;
        out_egr_port  <= desc_egr_port;
        out_prio      <= desc_prio;
        out_len       <= desc_len;
        out_drop_mark <= drop_mark;
    end

endmodule

`default_nettype wire

// ==== hw/ingress_policer.sv ====
// Top level of the per-port ingress policer with one cycle descriptor latency.
// Config writes and port enables come in as plain signals.
`default_nettype none

module ingress_policer
    import policer_pkg::*;
(
    input  logic                 core_clk_ifc,
    input  logic                 timer_reset,

    // Config write strobe
    input  logic                 cfg_valid,
    input  cfg_table_e           cfg_table,
    input  port_t                cfg_port,
    input  cbs_t                 cfg_data,

    input  logic [num_ports-1:0] enable,

    // Descriptor in
    input  logic                 desc_valid,
    input  port_t                desc_ing_port,
    input  port_t                desc_egr_port,
    input  prio_t                desc_prio,
    input  byte_len_t            desc_len,

    // Descriptor out with drop mark
    output logic                 out_valid,
    output port_t                out_ing_port,
    output port_t                out_egr_port,
    output prio_t                out_prio,
    output byte_len_t            out_len,
    output logic                 out_drop_mark
);

    cir_t      cir    [num_ports];
    cbs_t      cbs    [num_ports];
    level_t    levels [num_ports];

    logic      charge_valid;
    port_t     charge_port;
    byte_len_t charge_len;

    ////////////////////////////////////////////////////////////
    // Config tables

    policer_config_table u_config_table (
        .core_clk_ifc (core_clk_ifc),
        .timer_reset  (timer_reset),
        .cfg_valid    (cfg_valid),
        .cfg_table    (cfg_table),
        .cfg_port     (cfg_port),
        .cfg_data     (cfg_data),
        .cir          (cir),
        .cbs          (cbs)
    );

    ////////////////////////////////////////////////////////////
    // Buckets

    bucket_store u_bucket_store (
        .core_clk_ifc (core_clk_ifc),
        .timer_reset  (timer_reset),
        .cir          (cir),
        .charge_valid (charge_valid),
        .charge_port  (charge_port),
        .charge_len   (charge_len),
        .levels       (levels)
    );

    ////////////////////////////////////////////////////////////
    // Marking decision

    drop_marker u_drop_marker (
        .core_clk_ifc  (core_clk_ifc),
        .timer_reset   (timer_reset),
        .enable        (enable),
        .cbs           (cbs),
        .levels        (levels),
        .desc_valid    (desc_valid),
        .desc_ing_port (desc_ing_port),
        .desc_egr_port (desc_egr_port),
        .desc_prio     (desc_prio),
        .desc_len      (desc_len),
        .charge_valid  (charge_valid),
        .charge_port   (charge_port),
        .charge_len    (charge_len),
        .out_valid     (out_valid),
        .out_ing_port  (out_ing_port),
        .out_egr_port  (out_egr_port),
        .out_prio      (out_prio),
        .out_len       (out_len),
        .out_drop_mark (out_drop_mark)
    );

endmodule

`default_nettype wire

// ==== hw/policer_config_table.sv ====
// Per-port CIR and CBS registers, loaded one entry at a time by the config strobe.
// A write is in use from the cycle after the strobe.
`default_nettype none

module policer_config_table
    import policer_pkg::*;
(
    input  logic       core_clk_ifc,
    input  logic       timer_reset,

    input  logic       cfg_valid,
    input  cfg_table_e cfg_table,
    input  port_t      cfg_port,
    input  cbs_t       cfg_data,

    output cir_t       cir [num_ports],
    output cbs_t       cbs [num_ports]
);

    ////////////////////////////////////////////////////////////
    // Write decode

    logic [num_ports-1:0] port_hit;
    logic                 cir_we;
    logic                 cbs_we;

    // Ports at or above num_ports match no entry, so the write is dropped
    always_comb begin
        for (int i = 0; i < num_ports; i++) begin
            port_hit[i] = (cfg_port == port_t'(i));
        end
    end

    assign cir_we = cfg_valid && (cfg_table == cfg_cir_table);
    assign cbs_we = cfg_valid && (cfg_table == cfg_cbs_table);

    ////////////////////////////////////////////////////////////
    // Table registers

    always_ff @(posedge core_clk_ifc) begin
        if (timer_reset) begin
            for (int i = 0; i < num_ports; i++) begin
                cir[i] <= '0;
                cbs[i] <= '0;
            end
        end else begin
            for (int i = 0; i < num_ports; i++) begin
                if (cir_we && port_hit[i]) begin
                    // CIR and CBS share the 24 bit data field
                    cir[i] <= cir_t'(cfg_data);
                end
                if (cbs_we && port_hit[i]) begin
                    cbs[i] <= cfg_data;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/policer_pkg.sv ====
// Shared widths, fixed-point formats and table selects for the ingress policer.
// Imported by every policer module and by the testbench.
`default_nettype none

package policer_pkg;

    ////////////////////////////////////////////////////////////
    // Port counts

    localparam int num_ports     = 11;
    localparam int num_egr_ports = 11;

    ////////////////////////////////////////////////////////////
    // Field widths

    localparam int port_bits     = 4;
    localparam int prio_bits     = 3;
    // Enough for a 1500 byte MTU
    localparam int byte_len_bits = 11;

    ////////////////////////////////////////////////////////////
    // Fixed-point formats

    // CIR is bytes per cycle, 16.8
    localparam int cir_whole_bits = 16;
    localparam int cir_frac_bits  = 8;
    localparam int cir_bits       = cir_whole_bits + cir_frac_bits;

    // CBS in whole bytes
    localparam int cbs_bits = 24;

    // Bucket level keeps the same fraction as CIR so drains add up exactly
    localparam int level_whole_bits = 24;
    localparam int level_frac_bits  = cir_frac_bits;
    localparam int level_bits       = level_whole_bits + level_frac_bits;

    ////////////////////////////////////////////////////////////
    // Types

    typedef logic [port_bits-1:0]     port_t;
    typedef logic [prio_bits-1:0]     prio_t;
    typedef logic [byte_len_bits-1:0] byte_len_t;
    typedef logic [cir_bits-1:0]      cir_t;
    typedef logic [cbs_bits-1:0]      cbs_t;
    typedef logic [level_bits-1:0]    level_t;

    // Packet length plus whole bucket bytes, one carry bit wider than the level
    typedef logic [level_whole_bits:0] byte_sum_t;

    // Config table select on the write strobe
    typedef enum logic {
        cfg_cir_table = 1'b0,
        cfg_cbs_table = 1'b1
    } cfg_table_e;

endpackage

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# Build the policer testbench with Verilator and run it.
cd "$(dirname "$0")" || exit 1

verilator --binary --top-module policer_tb -f all.f -o policer_sim &&
    ./obj_dir/policer_sim | tee /dev/stderr | grep -q "TEST RESULT: PASS" &&
    echo "Simulation passed" && exit 0 ||
    { echo "Simulation failed"; exit 1; }

// ==== tb/policer_checker.sv ====
// Checker for the ingress policer. Queues expected descriptors and compares
// them with the DUT outputs, counting every failure.
`default_nettype none

module policer_checker
    import policer_pkg::*;
(
    input  logic      core_clk_ifc,
    input  logic      timer_reset,

    input  logic      exp_valid,
    input  port_t     exp_ing_port,
    input  port_t     exp_egr_port,
    input  prio_t     exp_prio,
    input  byte_len_t exp_len,
    input  logic      exp_mark,

    input  logic      out_valid,
    input  port_t     out_ing_port,
    input  port_t     out_egr_port,
    input  prio_t     out_prio,
    input  byte_len_t out_len,
    input  logic      out_drop_mark,

    output int        mismatch_count,
    output int        unexpected_count,
    output int        pending_count
);

    timeunit 1ns;
    timeprecision 1ps;

    typedef struct packed {
        port_t       ing_port;
        port_t       egr_port;
        prio_t       prio;
        byte_len_t   len;
        logic        mark;
        int unsigned cycle;
    } expect_t;

    expect_t     exp_q [$];
    int unsigned cycle_count;

    task automatic compare_field(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        if (expected !== actual) begin
            mismatch_count++;
            $display("ERR t=%0t %s expected %0h actual %0h", $time, name, expected, actual);
        end
    endtask

    // Falling edge, halfway between DUT updates and input changes
    always @(negedge core_clk_ifc) begin
        expect_t e;
        expect_t n;
        if (timer_reset) begin
            mismatch_count   = 0;
            unexpected_count = 0;
            cycle_count      = 0;
            exp_q.delete();
        end else begin
            cycle_count++;
            if (out_valid) begin
                if (exp_q.size() == 0) begin
                    unexpected_count++;
                    $display("Unexpected output at %0t on ingress port %0d",
                             $time, out_ing_port);
                end else begin
                    e = exp_q.pop_front();
                    // Every descriptor leaves exactly one cycle after it enters
                    if (cycle_count - e.cycle != 1) begin
                        unexpected_count++;
                        $display("Output at %0t on ingress port %0d came %0d cycles late",
                                 $time, out_ing_port, cycle_count - e.cycle);
                    end
                    compare_field("out_ing_port", 32'(e.ing_port), 32'(out_ing_port));
                    compare_field("out_egr_port", 32'(e.egr_port), 32'(out_egr_port));
                    compare_field("out_prio", 32'(e.prio), 32'(out_prio));
                    compare_field("out_len", 32'(e.len), 32'(out_len));
                    compare_field("out_drop_mark", 32'(e.mark), 32'(out_drop_mark));
                end
            end
            if (exp_valid) begin
                n.ing_port = exp_ing_port;
                n.egr_port = exp_egr_port;
                n.prio     = exp_prio;
                n.len      = exp_len;
                n.mark     = exp_mark;
                n.cycle    = cycle_count;
                exp_q.push_back(n);
            end
        end
        pending_count = exp_q.size();
    end

endmodule

`default_nettype wire

// ==== tb/policer_tb.sv ====
// Testbench top for the ingress policer. Applies a stimulus table in a loop
// and hands every descriptor's expected result to the checker.
`default_nettype none

module policer_tb
    import policer_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int clk_period   = 100;
    localparam int reset_cycles = 5;
    localparam int drive_delay  = 10;
    localparam int seed         = 57662;
    localparam int cir_flush    = 24'hFFFFFF;
    localparam int cbs_max      = 24'hFFFFFF;

    ////////////////////////////////////////////////////////////
    // DUT signals

    logic                 core_clk_ifc;
    logic                 timer_reset;
    logic                 cfg_valid;
    cfg_table_e           cfg_table;
    port_t                cfg_port;
    cbs_t                 cfg_data;
    logic [num_ports-1:0] enable;
    logic                 desc_valid;
    port_t                desc_ing_port;
    port_t                desc_egr_port;
    prio_t                desc_prio;
    byte_len_t            desc_len;
    logic                 out_valid;
    port_t                out_ing_port;
    port_t                out_egr_port;
    prio_t                out_prio;
    byte_len_t            out_len;
    logic                 out_drop_mark;

    // Expectations towards the checker
    logic                 exp_valid;
    logic                 exp_mark;
    int                   mismatch_count;
    int                   unexpected_count;
    int                   pending_count;

    ////////////////////////////////////////////////////////////
    // Stimulus table

    typedef enum logic [1:0] {
        row_cfg,
        row_enable,
        row_desc
    } row_kind_e;

    typedef struct packed {
        row_kind_e            kind;
        int                   idle;
        cfg_table_e           tbl;
        port_t                port;
        cbs_t                 data;
        logic [num_ports-1:0] en;
        byte_len_t            len;
        logic                 mark;
    } stim_row_t;

    stim_row_t   rows [$];
    logic [31:0] rnd_state;
    logic        table_ready;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x;
        y = y ^ (y << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic add_cfg(input int idle, input cfg_table_e tbl, input int port,
                           input int data);
        stim_row_t r;
        r.kind = row_cfg;
        r.idle = idle;
        r.tbl  = tbl;
        r.port = port_t'(port);
        r.data = cbs_t'(data);
        r.en   = '0;
        r.len  = '0;
        r.mark = 1'b0;
        rows.push_back(r);
    endtask

    task automatic add_enable(input int idle, input logic [num_ports-1:0] en);
        stim_row_t r;
        r.kind = row_enable;
        r.idle = idle;
        r.tbl  = cfg_cir_table;
        r.port = '0;
        r.data = '0;
        r.en   = en;
        r.len  = '0;
        r.mark = 1'b0;
        rows.push_back(r);
    endtask

    task automatic add_desc(input int idle, input int port, input int len,
                            input logic mark);
        stim_row_t r;
        r.kind = row_desc;
        r.idle = idle;
        r.tbl  = cfg_cir_table;
        r.port = port_t'(port);
        r.data = '0;
        r.en   = '0;
        r.len  = byte_len_t'(len);
        r.mark = mark;
        rows.push_back(r);
    endtask

    task automatic build_table();
        logic [num_ports-1:0] some_en;
        some_en = 11'h555;

        // Empty buckets with CIR and CBS zero, so everything is marked
        add_enable(0, '1);
        for (int i = 0; i < num_ports; i++) add_desc(0, i, 64 + 100 * i, 1'b1);

        // Maximum CBS accepts everything
        for (int i = 0; i < num_ports; i++) add_cfg(1, cfg_cbs_table, i, cbs_max);
        for (int i = 0; i < num_ports; i++) add_desc(0, i, 100 + 50 * i, 1'b0);

        // Port 3, CBS 1000 and CIR zero, after flushing the bucket
        add_cfg(0, cfg_cir_table, 3, cir_flush);
        add_cfg(3, cfg_cir_table, 3, 0);
        add_cfg(0, cfg_cbs_table, 3, 1000);
        add_desc(0, 3, 400, 1'b0);
        // Back to back, the second sees the charge of the first
        add_desc(0, 3, 700, 1'b1);
        add_desc(0, 3, 500, 1'b0);
        add_desc(0, 3, 200, 1'b1);
        add_desc(0, 3, 100, 1'b0);
        add_desc(0, 3, 1, 1'b1);

        // Port 7 drains 10 bytes per cycle against CBS 1000
        add_cfg(0, cfg_cir_table, 7, cir_flush);
        add_cfg(3, cfg_cbs_table, 7, 1000);
        add_cfg(0, cfg_cir_table, 7, 10 << cir_frac_bits);
        add_desc(0, 7, 1000, 1'b0);
        add_desc(50, 7, 1000, 1'b1);
        add_desc(60, 7, 1000, 1'b0);

        // CBS zero everywhere, only even ports enabled
        for (int i = 0; i < num_ports; i++) add_cfg(0, cfg_cbs_table, i, 0);
        add_enable(1, some_en);
        for (int i = 0; i < num_ports; i++) add_desc(0, i, 200 + i, some_en[i]);
    endtask

    ////////////////////////////////////////////////////////////
    // Clock and DUT

    initial begin
        core_clk_ifc = 1'b0;
        forever #(clk_period / 2) core_clk_ifc = ~core_clk_ifc;
    end

    ingress_policer DUT (
        .core_clk_ifc  (core_clk_ifc),
        .timer_reset   (timer_reset),
        .cfg_valid     (cfg_valid),
        .cfg_table     (cfg_table),
        .cfg_port      (cfg_port),
        .cfg_data      (cfg_data),
        .enable        (enable),
        .desc_valid    (desc_valid),
        .desc_ing_port (desc_ing_port),
        .desc_egr_port (desc_egr_port),
        .desc_prio     (desc_prio),
        .desc_len      (desc_len),
        .out_valid     (out_valid),
        .out_ing_port  (out_ing_port),
        .out_egr_port  (out_egr_port),
        .out_prio      (out_prio),
        .out_len       (out_len),
        .out_drop_mark (out_drop_mark)
    );

    policer_checker u_checker (
        .core_clk_ifc     (core_clk_ifc),
        .timer_reset      (timer_reset),
        .exp_valid        (exp_valid),
        .exp_ing_port     (desc_ing_port),
        .exp_egr_port     (desc_egr_port),
        .exp_prio         (desc_prio),
        .exp_len          (desc_len),
        .exp_mark         (exp_mark),
        .out_valid        (out_valid),
        .out_ing_port     (out_ing_port),
        .out_egr_port     (out_egr_port),
        .out_prio         (out_prio),
        .out_len          (out_len),
        .out_drop_mark    (out_drop_mark),
        .mismatch_count   (mismatch_count),
        .unexpected_count (unexpected_count),
        .pending_count    (pending_count)
    );

    ////////////////////////////////////////////////////////////
    // Row driver

    task automatic clear_strobes();
        cfg_valid  = 1'b0;
        desc_valid = 1'b0;
        exp_valid  = 1'b0;
    endtask

    task automatic apply_row(input stim_row_t r);
        repeat (r.idle) begin
            @(posedge core_clk_ifc);
            #(drive_delay);
            clear_strobes();
        end
        @(posedge core_clk_ifc);
        #(drive_delay);
        clear_strobes();
        case (r.kind)
            row_cfg: begin
                cfg_valid = 1'b1;
                cfg_table = r.tbl;
                cfg_port  = r.port;
                cfg_data  = r.data;
            end
            row_enable: begin
                enable = r.en;
            end
            default: begin
                // Egress port and prio are free fields, filled at random
                rnd_state     = xorshift32(rnd_state);
                desc_egr_port = port_t'(rnd_state % num_egr_ports);
                rnd_state     = xorshift32(rnd_state);
                desc_prio     = prio_t'(rnd_state[2:0]);
                desc_valid    = 1'b1;
                desc_ing_port = r.port;
                desc_len      = r.len;
                exp_valid     = 1'b1;
                exp_mark      = r.mark;
            end
        endcase
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence

    initial begin
        int total;
        timer_reset   = 1'b1;
        cfg_valid     = 1'b0;
        cfg_table     = cfg_cir_table;
        cfg_port      = '0;
        cfg_data      = '0;
        enable        = '0;
        desc_valid    = 1'b0;
        desc_ing_port = '0;
        desc_egr_port = '0;
        desc_prio     = '0;
        desc_len      = '0;
        exp_valid     = 1'b0;
        exp_mark      = 1'b0;
        rnd_state     = seed;
        table_ready   = 1'b0;

        build_table();
        table_ready = 1'b1;

        repeat (reset_cycles) @(posedge core_clk_ifc);
        #(drive_delay);
        timer_reset = 1'b0;

        foreach (rows[i]) apply_row(rows[i]);
        @(posedge core_clk_ifc);
        #(drive_delay);
        clear_strobes();

        // Room for the last output and for any stray ones
        repeat (3) @(posedge core_clk_ifc);

        total = mismatch_count + unexpected_count + pending_count;
        if (pending_count != 0) begin
            $display("Missing outputs: %0d expected descriptors never came out",
                     pending_count);
        end
        $display("Errors: %0d mismatched, %0d unexpected, %0d missing",
                 mismatch_count, unexpected_count, pending_count);
        if (total == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    // Watchdog sized from the table length and its idle cycles
    initial begin
        int limit_cycles;
        wait (table_ready);
        limit_cycles = reset_cycles + rows.size() + 20;
        foreach (rows[i]) limit_cycles += rows[i].idle;
        #(limit_cycles * clk_period);
        $display("Timeout: the run did not finish within %0d cycles", limit_cycles);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire
